//--- fpu_pkg.sv
package fpu_pkg;

  // double format field widths
  localparam int EXP_W = 11;
  localparam int MAN_W = 52;
  localparam int FP_W  = 64;

  // exception flag vector layout
  localparam int FLAG_W        = 3;
  localparam int FLAG_INEXACT  = 0;
  localparam int FLAG_OVERFLOW = 1;
  localparam int FLAG_INVALID  = 2;

  typedef enum logic [3:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_rsub   = 4'd2,
    op_cmp_lt = 4'd4,
    op_cmp_eq = 4'd5,
    op_cmp_le = 4'd6,
    op_and    = 4'd8,
    op_or     = 4'd9,
    op_xor    = 4'd10
  } fp_op_e;

  // operand source at issue
  typedef enum logic [2:0] {
    src_reg      = 3'd0,
    src_own_now  = 3'd1,
    src_own_prev = 3'd2,
    src_ext_now  = 3'd3,
    src_ext_prev = 3'd4
  } fwd_src_e;

  // true for ops that go down the adder path
  function automatic logic is_add_op(input fp_op_e op);
    return (op == op_add) || (op == op_sub) || (op == op_rsub);
  endfunction

endpackage

//--- fp_operand_forward.sv
`timescale 1ns/1ps

module fp_operand_forward
  import fpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  fwd_src_e        sel,
  input  logic [FP_W-1:0] reg_val,
  input  logic [FP_W-1:0] own_res,
  input  logic [FP_W-1:0] ext_res,
  output logic [FP_W-1:0] operand
);

  logic [FP_W-1:0] own_prev;
  logic [FP_W-1:0] ext_prev;

  // one-cycle-old copies of both result buses
  always_ff @(posedge clk) begin
    if (rst) begin
      own_prev <= '0;
      ext_prev <= '0;
    end else begin
      own_prev <= own_res;
      ext_prev <= ext_res;
    end
  end

  always_comb begin
    case (sel)
      src_own_now: begin
        operand = own_res;
      end
      src_own_prev: begin
        operand = own_prev;
      end
      src_ext_now: begin
        operand = ext_res;
      end
      src_ext_prev: begin
        operand = ext_prev;
      end
      default: begin
        operand = reg_val;
      end
    endcase
  end

endmodule

//--- fp_add_core.sv
`timescale 1ns/1ps

module fp_add_core
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [FP_W-1:0]   a,
  input  logic [FP_W-1:0]   b,
  input  logic              negate_b,
  input  logic              swap,
  output logic              out_valid,
  output logic [FP_W-1:0]   sum,
  output logic [FLAG_W-1:0] raised
);

  localparam int SIG_W = MAN_W + 1;
  // significand plus guard, round and sticky
  localparam int EXT_W = SIG_W + 3;
  localparam logic [EXP_W-1:0] EXP_MAX = '1;
  localparam logic [FP_W-1:0] QNAN = {1'b0, EXP_MAX, 1'b1, {(MAN_W-1){1'b0}}};

  function automatic logic [5:0] lead_zeros(input logic [EXT_W-1:0] v);
    logic [5:0] n;
    n = 6'(EXT_W);
    for (int i = 0; i < EXT_W; i++) begin
      if (v[i]) begin
        n = 6'(EXT_W - 1 - i);
      end
    end
    return n;
  endfunction

  logic [FP_W-1:0]    x;
  logic [FP_W-1:0]    y;
  logic               sx;
  logic               sy;
  logic [EXP_W-1:0]   ex;
  logic [EXP_W-1:0]   ey;
  logic [SIG_W-1:0]   mx;
  logic [SIG_W-1:0]   my;
  logic               x_nan;
  logic               y_nan;
  logic               x_inf;
  logic               y_inf;
  logic               x_big;
  logic [EXP_W-1:0]   e_diff;
  logic [SIG_W-1:0]   m_small;
  logic [5:0]         sh;
  logic [2*EXT_W-1:0] wide;
  logic [FP_W-1:0]    sp_val;

  logic               s1_valid;
  logic               s1_sub;
  logic               s1_sign;
  logic [EXP_W-1:0]   s1_exp;
  logic [EXT_W-1:0]   s1_big;
  logic [EXT_W-1:0]   s1_small;
  logic               s1_sp;
  logic               s1_inv;
  logic [FP_W-1:0]    s1_spval;

  logic [EXT_W:0]     raw;
  logic [5:0]         lz;
  logic [EXT_W-1:0]   norm;
  logic [EXP_W:0]     exp_n;
  logic               zero_n;

  logic               s2_valid;
  logic               s2_sign;
  logic [EXP_W:0]     s2_exp;
  logic [EXT_W-1:0]   s2_man;
  logic               s2_zero;
  logic               s2_sp;
  logic               s2_inv;
  logic [FP_W-1:0]    s2_spval;

  logic               rnd_up;
  logic [SIG_W:0]     rnd;
  logic [EXP_W:0]     exp_r;
  logic [MAN_W-1:0]   frac;
  logic [FP_W-1:0]    sum_n;
  logic [FLAG_W-1:0]  raised_n;

  // stage 1: operand order, effective sign, alignment
  always_comb begin
    x = swap ? b : a;
    y = swap ? a : b;
    sx = x[FP_W-1];
    sy = y[FP_W-1] ^ negate_b;
    ex = x[FP_W-2:MAN_W];
    ey = y[FP_W-2:MAN_W];
    // denormals flush to zero
    mx = (ex != '0) ? {1'b1, x[MAN_W-1:0]} : '0;
    my = (ey != '0) ? {1'b1, y[MAN_W-1:0]} : '0;
    x_nan = (ex == EXP_MAX) && (x[MAN_W-1:0] != '0);
    y_nan = (ey == EXP_MAX) && (y[MAN_W-1:0] != '0);
    x_inf = (ex == EXP_MAX) && (x[MAN_W-1:0] == '0);
    y_inf = (ey == EXP_MAX) && (y[MAN_W-1:0] == '0);
    x_big = {ex, mx} >= {ey, my};
    e_diff = x_big ? ex - ey : ey - ex;
    m_small = x_big ? my : mx;
    sh = (e_diff > 11'd56) ? 6'd56 : e_diff[5:0];
    wide = {m_small, 3'b000, {EXT_W{1'b0}}} >> sh;
    if (x_nan || y_nan || (x_inf && y_inf && (sx != sy))) begin
      sp_val = QNAN;
    end else if (x_inf) begin
      sp_val = {sx, EXP_MAX, {MAN_W{1'b0}}};
    end else begin
      sp_val = {sy, EXP_MAX, {MAN_W{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_sub <= sx ^ sy;
    s1_sign <= x_big ? sx : sy;
    s1_exp <= x_big ? ex : ey;
    s1_big <= {(x_big ? mx : my), 3'b000};
    s1_small <= {wide[2*EXT_W-1:EXT_W+1], wide[EXT_W] | (|wide[EXT_W-1:0])};
    s1_sp <= (ex == EXP_MAX) || (ey == EXP_MAX);
    s1_inv <= x_nan || y_nan || (x_inf && y_inf && (sx != sy));
    s1_spval <= sp_val;
  end

  // stage 2: add or subtract, then normalize
  always_comb begin
    if (s1_sub) begin
      raw = {1'b0, s1_big} - {1'b0, s1_small};
    end else begin
      raw = {1'b0, s1_big} + {1'b0, s1_small};
    end
    lz = lead_zeros(raw[EXT_W-1:0]);
    if (raw[EXT_W]) begin
      norm = {raw[EXT_W:2], raw[1] | raw[0]};
      exp_n = {1'b0, s1_exp} + {{EXP_W{1'b0}}, 1'b1};
      zero_n = 1'b0;
    end else begin
      norm = raw[EXT_W-1:0] << lz;
      exp_n = {1'b0, s1_exp} - {6'd0, lz};
      zero_n = (raw == '0) || (s1_exp <= {5'd0, lz});
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_sign <= s1_sign;
    s2_exp <= exp_n;
    s2_man <= norm;
    s2_zero <= zero_n;
    s2_sp <= s1_sp;
    s2_inv <= s1_inv;
    s2_spval <= s1_spval;
  end

  // stage 3: round to nearest even and pack
  always_comb begin
    rnd_up = s2_man[2] & (s2_man[3] | s2_man[1] | s2_man[0]);
    rnd = {1'b0, s2_man[EXT_W-1:3]} + {{SIG_W{1'b0}}, rnd_up};
    exp_r = s2_exp + {{EXP_W{1'b0}}, rnd[SIG_W]};
    // carry-out leaves the fraction zero
    frac = rnd[MAN_W-1:0];
    raised_n = '0;
    if (s2_sp) begin
      sum_n = s2_spval;
      raised_n[FLAG_INVALID] = s2_inv;
    end else if (s2_zero) begin
      sum_n = '0;
    end else if (exp_r >= {1'b0, EXP_MAX}) begin
      sum_n = {s2_sign, EXP_MAX, {MAN_W{1'b0}}};
      raised_n[FLAG_OVERFLOW] = 1'b1;
      raised_n[FLAG_INEXACT] = 1'b1;
    end else begin
      sum_n = {s2_sign, exp_r[EXP_W-1:0], frac};
      raised_n[FLAG_INEXACT] = |s2_man[2:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    sum <= sum_n;
    raised <= raised_n;
  end

endmodule

//--- fp_cmp_logic.sv
`timescale 1ns/1ps

module fp_cmp_logic
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  fp_op_e            op,
  input  logic [FP_W-1:0]   a,
  input  logic [FP_W-1:0]   b,
  output logic              out_valid,
  output logic [FP_W-1:0]   result,
  output logic [FLAG_W-1:0] raised
);

  // matches the adder latency
  localparam int DEPTH = 3;

  logic              a_nan;
  logic              b_nan;
  logic              both_zero;
  logic              ordered;
  logic              lt;
  logic              eq;
  logic [FP_W-1:0]   res_n;
  logic [FLAG_W-1:0] raised_n;

  logic [DEPTH-1:0]  valid_q;
  logic [FP_W-1:0]   res_q [DEPTH];
  logic [FLAG_W-1:0] flag_q [DEPTH];

  always_comb begin
    a_nan = (a[FP_W-2:MAN_W] == '1) && (a[MAN_W-1:0] != '0);
    b_nan = (b[FP_W-2:MAN_W] == '1) && (b[MAN_W-1:0] != '0);
    // zero exponent counts as zero, so +0 == -0
    both_zero = (a[FP_W-2:MAN_W] == '0) && (b[FP_W-2:MAN_W] == '0);
    ordered = !a_nan && !b_nan;
    eq = both_zero || (a == b);
    // sign-magnitude ordering
    lt = !both_zero &&
         ((a[FP_W-1] && !b[FP_W-1]) ||
          (!a[FP_W-1] && !b[FP_W-1] && (a[FP_W-2:0] < b[FP_W-2:0])) ||
          (a[FP_W-1] && b[FP_W-1] && (a[FP_W-2:0] > b[FP_W-2:0])));
    res_n = '0;
    raised_n = '0;
    case (op)
      op_cmp_lt: res_n[0] = ordered && lt;
      op_cmp_eq: res_n[0] = ordered && eq;
      op_cmp_le: res_n[0] = ordered && (lt || eq);
      op_and:    res_n = a & b;
      op_or:     res_n = a | b;
      op_xor:    res_n = a ^ b;
      default:   res_n = '0;
    endcase
    if ((op == op_cmp_lt) || (op == op_cmp_eq) || (op == op_cmp_le)) begin
      raised_n[FLAG_INVALID] = !ordered;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[DEPTH-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    res_q[0] <= res_n;
    flag_q[0] <= raised_n;
    for (int i = 1; i < DEPTH; i++) begin
      res_q[i] <= res_q[i-1];
      flag_q[i] <= flag_q[i-1];
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign result = res_q[DEPTH-1];
  assign raised = flag_q[DEPTH-1];

endmodule

//--- fp_exception.sv
`timescale 1ns/1ps

module fp_exception
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [FLAG_W-1:0] raised,
  input  logic [FLAG_W-1:0] exc_enable,
  output logic [FLAG_W-1:0] flags,
  output logic              trap
);

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
      trap <= 1'b0;
    end else if (in_valid) begin
      flags <= raised;
      // trap on any enabled flag
      trap <= |(raised & exc_enable);
    end else begin
      flags <= '0;
      trap <= 1'b0;
    end
  end

endmodule

//--- fp_add_unit.sv
`timescale 1ns/1ps

module fp_add_unit
  import fpu_pkg::*;
#(
  parameter int TAG_W = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  fp_op_e            op,
  input  logic [TAG_W-1:0]  tag,
  input  logic [FP_W-1:0]   a_reg,
  input  logic [FP_W-1:0]   b_reg,
  input  fwd_src_e          fwd_a,
  input  fwd_src_e          fwd_b,
  input  logic [FP_W-1:0]   ext_res,
  input  logic [FLAG_W-1:0] exc_enable,
  output logic [FP_W-1:0]   res,
  output logic              res_valid,
  output logic [TAG_W-1:0]  res_tag,
  output logic [FLAG_W-1:0] flags,
  output logic              trap
);

  // latency of both execution paths after issue
  localparam int PIPE = 3;

  logic [FP_W-1:0]   a_fwd;
  logic [FP_W-1:0]   b_fwd;

  logic              add_v_q;
  logic              cmp_v_q;
  fp_op_e            op_q;
  logic              negate_q;
  logic              swap_q;
  logic [FP_W-1:0]   a_q;
  logic [FP_W-1:0]   b_q;
  logic [TAG_W-1:0]  tag_q;

  logic [TAG_W-1:0]  tag_pipe [PIPE];
  logic [PIPE-1:0]   cmp_path;

  logic              add_ov;
  logic [FP_W-1:0]   add_sum;
  logic [FLAG_W-1:0] add_raised;
  logic              cmp_ov;
  logic [FP_W-1:0]   cmp_res;
  logic [FLAG_W-1:0] cmp_raised;
  logic              end_valid;
  logic [FLAG_W-1:0] end_raised;

  fp_operand_forward i_fwd_a (
    .clk     (clk),
    .rst     (rst),
    .sel     (fwd_a),
    .reg_val (a_reg),
    .own_res (res),
    .ext_res (ext_res),
    .operand (a_fwd)
  );

  fp_operand_forward i_fwd_b (
    .clk     (clk),
    .rst     (rst),
    .sel     (fwd_b),
    .reg_val (b_reg),
    .own_res (res),
    .ext_res (ext_res),
    .operand (b_fwd)
  );

  // issue stage, one valid per path
  always_ff @(posedge clk) begin
    if (rst) begin
      add_v_q <= 1'b0;
      cmp_v_q <= 1'b0;
    end else begin
      add_v_q <= en && is_add_op(op);
      cmp_v_q <= en && !is_add_op(op);
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      op_q <= op;
      negate_q <= (op == op_sub) || (op == op_rsub);
      swap_q <= (op == op_rsub);
      a_q <= a_fwd;
      b_q <= b_fwd;
      tag_q <= tag;
    end
  end

  fp_add_core i_add (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (add_v_q),
    .a         (a_q),
    .b         (b_q),
    .negate_b  (negate_q),
    .swap      (swap_q),
    .out_valid (add_ov),
    .sum       (add_sum),
    .raised    (add_raised)
  );

  fp_cmp_logic i_cmp (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (cmp_v_q),
    .op        (op_q),
    .a         (a_q),
    .b         (b_q),
    .out_valid (cmp_ov),
    .result    (cmp_res),
    .raised    (cmp_raised)
  );

  // tag and path select ride alongside
  always_ff @(posedge clk) begin
    tag_pipe[0] <= tag_q;
    cmp_path <= {cmp_path[PIPE-2:0], cmp_v_q};
    for (int i = 1; i < PIPE; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
    end
  end

  assign end_valid = add_ov || cmp_ov;
  assign end_raised = cmp_path[PIPE-1] ? cmp_raised : add_raised;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= end_valid;
    end
  end

  // res holds the last result for own forwarding
  always_ff @(posedge clk) begin
    if (end_valid) begin
      res <= cmp_path[PIPE-1] ? cmp_res : add_sum;
      res_tag <= tag_pipe[PIPE-1];
    end
  end

  fp_exception i_exc (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (end_valid),
    .raised     (end_raised),
    .exc_enable (exc_enable),
    .flags      (flags),
    .trap       (trap)
  );

endmodule

//--- tb_fp_add_unit.sv
`timescale 1ns/1ps

module tb_fp_add_unit
  import fpu_pkg::*;
();

  localparam int TAG_W = 4;
  localparam int SEED = 32'hee5d;
  localparam int DRAIN_TIMEOUT = 40;
  localparam logic [63:0] QNAN = 64'h7ff8_0000_0000_0000;
  localparam logic [63:0] P_INF = 64'h7ff0_0000_0000_0000;
  localparam logic [63:0] N_INF = 64'hfff0_0000_0000_0000;

  typedef struct packed {
    logic [31:0]       due;
    logic [TAG_W-1:0]  tag;
    logic [63:0]       val;
    logic [FLAG_W-1:0] fl;
    logic              trap;
  } exp_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              en;
  fp_op_e            op;
  logic [TAG_W-1:0]  tag;
  logic [63:0]       a_reg;
  logic [63:0]       b_reg;
  fwd_src_e          fwd_a;
  fwd_src_e          fwd_b;
  logic [63:0]       ext_res;
  logic [FLAG_W-1:0] exc_enable;
  logic [63:0]       res;
  logic              res_valid;
  logic [TAG_W-1:0]  res_tag;
  logic [FLAG_W-1:0] flags;
  logic              trap;

  int               cyc = 0;
  int               errors = 0;
  int               checks = 0;
  bit               timed_out = 1'b0;
  exp_t             sb [$];
  logic [TAG_W-1:0] tag_cnt = '0;
  // model of the result bus, now and one cycle back
  logic [63:0]      own_cur;
  logic [63:0]      own_prev;
  logic [63:0]      ext_last = '0;
  logic [63:0]      pend_val [8];
  bit               pend_v [8];

  fp_add_unit #(.TAG_W(TAG_W)) i_dut (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .op         (op),
    .tag        (tag),
    .a_reg      (a_reg),
    .b_reg      (b_reg),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .ext_res    (ext_res),
    .exc_enable (exc_enable),
    .res        (res),
    .res_valid  (res_valid),
    .res_tag    (res_tag),
    .flags      (flags),
    .trap       (trap)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic bit is_nan(input logic [63:0] v);
    return (v[62:52] == 11'h7ff) && (v[51:0] != '0);
  endfunction

  function automatic bit is_inf(input logic [63:0] v);
    return (v[62:52] == 11'h7ff) && (v[51:0] == '0);
  endfunction

  // expected value and raised flags from the IEEE rules
  function automatic logic [63:0] fp_ref(input fp_op_e o, input logic [63:0] a_in,
                                         input logic [63:0] b_in,
                                         output logic [FLAG_W-1:0] fl);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] r;
    real         rx;
    real         ry;
    real         rs;
    real         rv;
    real         err;
    fl = '0;
    r = '0;
    // denormals count as zero
    a = (a_in[62:52] == '0) ? {a_in[63], 63'd0} : a_in;
    b = (b_in[62:52] == '0) ? {b_in[63], 63'd0} : b_in;
    if ((o == op_add) || (o == op_sub) || (o == op_rsub)) begin
      x = (o == op_rsub) ? b : a;
      y = (o == op_rsub) ? a : b;
      if (o != op_add) begin
        y[63] = ~y[63];
      end
      if (is_nan(x) || is_nan(y) || (is_inf(x) && is_inf(y) && (x[63] != y[63]))) begin
        r = QNAN;
        fl[FLAG_INVALID] = 1'b1;
      end else if (is_inf(x)) begin
        r = x;
      end else if (is_inf(y)) begin
        r = y;
      end else begin
        rx = $bitstoreal(x);
        ry = $bitstoreal(y);
        rs = rx + ry;
        r = $realtobits(rs);
        if (r[62:52] == 11'h7ff) begin
          fl[FLAG_OVERFLOW] = 1'b1;
          fl[FLAG_INEXACT] = 1'b1;
        end else begin
          // two-sum error term
          rv = rs - rx;
          err = (rx - (rs - rv)) + (ry - rv);
          fl[FLAG_INEXACT] = (err != 0.0);
          if (rs == 0.0) begin
            r = '0;
          end
        end
      end
    end else if ((o == op_and) || (o == op_or) || (o == op_xor)) begin
      r = (o == op_and) ? (a_in & b_in) : (o == op_or) ? (a_in | b_in) : (a_in ^ b_in);
    end else if (is_nan(a) || is_nan(b)) begin
      fl[FLAG_INVALID] = 1'b1;
    end else begin
      rx = $bitstoreal(a);
      ry = $bitstoreal(b);
      if (o == op_cmp_lt) begin
        r[0] = (rx < ry);
      end else if (o == op_cmp_eq) begin
        r[0] = (rx == ry);
      end else begin
        r[0] = (rx <= ry);
      end
    end
    return r;
  endfunction

  function automatic logic [63:0] rand_double();
    logic [10:0] e;
    e = 11'(1003 + $urandom % 41);
    return {1'($urandom), e, 20'($urandom), $urandom};
  endfunction

  function automatic logic [63:0] source_value(input fwd_src_e s, input logic [63:0] r);
    case (s)
      src_own_now: return own_cur;
      src_own_prev: return own_prev;
      src_ext_now: return ext_res;
      src_ext_prev: return ext_last;
      default: return r;
    endcase
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp_v);
    checks++;
    if (got !== exp_v) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp_v);
    end
  endtask

  // advance one edge, drive 1 ns later
  task automatic next_cycle();
    int slot;
    @(posedge clk);
    #1;
    slot = cyc % 8;
    en = 1'b0;
    own_prev = own_cur;
    if (pend_v[slot]) begin
      own_cur = pend_val[slot];
      pend_v[slot] = 1'b0;
    end
    ext_last = ext_res;
    ext_res = {$urandom, $urandom};
  endtask

  task automatic issue(input fp_op_e o, input logic [63:0] a, input logic [63:0] b,
                       input fwd_src_e fa, input fwd_src_e fb);
    logic [63:0]       v;
    logic [FLAG_W-1:0] fl;
    exp_t              e;
    int                slot;
    v = fp_ref(o, source_value(fa, a), source_value(fb, b), fl);
    en = 1'b1;
    op = o;
    tag = tag_cnt;
    a_reg = a;
    b_reg = b;
    fwd_a = fa;
    fwd_b = fb;
    // sampled on the next edge, result four edges after that
    e.due = 32'(cyc + 5);
    e.tag = tag_cnt;
    e.val = v;
    e.fl = fl;
    e.trap = |(fl & exc_enable);
    sb.push_back(e);
    slot = (cyc + 5) % 8;
    pend_val[slot] = v;
    pend_v[slot] = 1'b1;
    tag_cnt = tag_cnt + TAG_W'(1);
    next_cycle();
  endtask

  task automatic gap();
    int n;
    n = 0;
    if ($urandom % 3 == 0) begin
      n = 1 + $urandom % 3;
    end
    repeat (n) next_cycle();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((sb.size() != 0) && (n < DRAIN_TIMEOUT)) begin
      next_cycle();
      n++;
    end
    if (sb.size() != 0) begin
      $display("Timeout at %0t: %0d results never came out", $time, sb.size());
      errors++;
      timed_out = 1'b1;
      sb.delete();
    end
  endtask

  task automatic run_arith();
    fp_op_e      ops [3];
    logic [63:0] a;
    logic [63:0] b;
    int          k;
    ops = '{op_add, op_sub, op_rsub};
    exc_enable = 3'b001;
    for (int i = 0; i < 60; i++) begin
      k = $urandom % 3;
      a = rand_double();
      b = rand_double();
      // cancellation to zero
      if (i % 8 == 3) begin
        b = (k == 0) ? {~a[63], a[62:0]} : a;
      end else if (i % 8 == 5) begin
        b[62:52] = a[62:52];
      end
      issue(ops[k], a, b, src_reg, src_reg);
      gap();
    end
  endtask

  task automatic run_cmp_logic();
    fp_op_e      ops [6];
    logic [63:0] a;
    logic [63:0] b;
    ops = '{op_cmp_lt, op_cmp_eq, op_cmp_le, op_and, op_or, op_xor};
    exc_enable = 3'b100;
    for (int i = 0; i < 60; i++) begin
      a = rand_double();
      b = rand_double();
      case (i % 6)
        1: b = a;
        2: begin
          a = 64'd0;
          b = 64'h8000_0000_0000_0000;
        end
        3: a = 64'h7ff0_0000_0000_0001;
        4: b = 64'hfff8_0000_0000_0000;
        5: b = {~a[63], a[62:0]};
        default: ;
      endcase
      issue(ops[$urandom % 6], a, b, src_reg, src_reg);
      gap();
    end
  endtask

  task automatic run_forwarding();
    fp_op_e   ops [3];
    fwd_src_e fa;
    fwd_src_e fb;
    ops = '{op_add, op_sub, op_rsub};
    exc_enable = 3'b000;
    // fill the result bus with arithmetic results first
    for (int i = 0; i < 6; i++) begin
      issue(op_add, rand_double(), rand_double(), src_reg, src_reg);
    end
    for (int i = 0; i < 50; i++) begin
      fa = fwd_src_e'($urandom % 5);
      fb = fwd_src_e'($urandom % 5);
      issue(ops[$urandom % 3], rand_double(), rand_double(), fa, fb);
      if ($urandom % 4 == 0) begin
        next_cycle();
      end
    end
  endtask

  task automatic run_exceptions();
    logic [FLAG_W-1:0] masks [5];
    logic [63:0]       big;
    masks = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b111};
    for (int m = 0; m < 5; m++) begin
      exc_enable = masks[m];
      big = {1'b0, 11'h7fe, 20'($urandom), $urandom};
      issue(op_add, big, big, src_reg, src_reg);
      issue(op_sub, {1'b1, big[62:0]}, big, src_reg, src_reg);
      issue(op_sub, P_INF, P_INF, src_reg, src_reg);
      issue(op_add, N_INF, P_INF, src_reg, src_reg);
      issue(op_add, rand_double(), rand_double(), src_reg, src_reg);
      issue(op_cmp_le, QNAN, rand_double(), src_reg, src_reg);
      issue(op_rsub, P_INF, rand_double(), src_reg, src_reg);
      drain();
    end
  endtask

  // scoreboard side, sampled mid-cycle
  always @(negedge clk) begin
    exp_t e;
    if (!rst) begin
      if ((sb.size() != 0) && (int'(sb[0].due) < cyc)) begin
        errors++;
        $display("Result with tag %0d did not appear by %0t", sb[0].tag, $time);
        void'(sb.pop_front());
      end
      if (res_valid) begin
        if (sb.size() == 0) begin
          errors++;
          $display("Unexpected result at %0t with tag %0d", $time, res_tag);
        end else begin
          e = sb.pop_front();
          check("latency", 64'(cyc), 64'(e.due));
          check("tag", 64'(res_tag), 64'(e.tag));
          check("res", res, e.val);
          check("flags", 64'(flags), 64'(e.fl));
          check("trap", 64'(trap), 64'(e.trap));
        end
      end else begin
        // no flags or trap between results
        check("idle flags", 64'(flags), 64'd0);
        check("idle trap", 64'(trap), 64'd0);
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    en = 1'b0;
    op = op_add;
    tag = '0;
    a_reg = '0;
    b_reg = '0;
    fwd_a = src_reg;
    fwd_b = src_reg;
    ext_res = '0;
    exc_enable = '0;
    for (int i = 0; i < 8; i++) begin
      pend_v[i] = 1'b0;
    end
    repeat (5) next_cycle();
    rst = 1'b0;
    // nothing may come out before the first issue
    repeat (8) next_cycle();
    run_arith();
    drain();
    run_cmp_logic();
    drain();
    run_forwarding();
    drain();
    run_exceptions();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if ((errors == 0) && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb.f
fpu_pkg.sv
fp_operand_forward.sv
fp_add_core.sv
fp_cmp_logic.sv
fp_exception.sv
fp_add_unit.sv
tb_fp_add_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_fp_add_unit \
  -f tb.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi

echo "simulation finished cleanly"
